// File: hw/i2s_pkg.sv
// Shared types and constants of the I2S transmitter.
package i2s_pkg;

   // Bits per audio sample.
   localparam int sample_width = 24;

   // Bit periods per channel slot.
   // 24 data bits plus one zero overhead bit.
   localparam int slot_bits = 25;

   // Width of the in-slot bit counter.
   localparam int slot_cnt_w = $clog2(slot_bits);

   // One stereo frame as written by the host.
   // Left sample sits in the upper half, right in the lower half.
   typedef struct packed {
      logic [sample_width-1:0] left;   // Sent while lrclk is low.
      logic [sample_width-1:0] right;  // Sent while lrclk is high.
   } audio_frame_t;

   // Channel state of the serializer.
   // The encoding is the lrclk level itself.
   typedef enum logic {
      chan_left  = 1'b0,  // lrclk low.
      chan_right = 1'b1   // lrclk high.
   } chan_t;

endpackage

// File: hw/audio_frame_fifo.sv
`timescale 1ns/1ns

// First-word-fall-through frame FIFO.
// head always shows the oldest frame while empty is low.
module audio_frame_fifo #(
   parameter int fifo_depth = 16  // Frames held, power of two.
) (
   input  logic                  clk,
   input  logic                  reset,
   input  i2s_pkg::audio_frame_t din,    // Frame from the host.
   input  logic                  wr_en,  // One-cycle write strobe.
   output logic                  full,
   input  logic                  pop,    // Removes head at the clock edge.
   output i2s_pkg::audio_frame_t head,
   output logic                  empty
);

   localparam int ptr_w = $clog2(fifo_depth);
   localparam int cnt_w = $clog2(fifo_depth + 1);  // Must hold fifo_depth itself.
   localparam logic [cnt_w-1:0] cnt_full = cnt_w'(fifo_depth);

   i2s_pkg::audio_frame_t mem [fifo_depth];  // Frame storage.

   logic [ptr_w-1:0] wr_ptr;      // Next slot to fill.
   logic [ptr_w-1:0] rd_ptr;      // Oldest frame.
   logic [cnt_w-1:0] count;       // Frames stored.
   logic [cnt_w-1:0] count_next;
   logic             do_write;
   logic             do_read;

   // Writes while full are dropped.
   assign do_write = wr_en && !full;
   assign do_read  = pop && !empty;  // Guard against a bad pop.

   // Fall-through read port.
   assign head = mem[rd_ptr];

   // Occupancy after this edge.
   always_comb begin
      count_next = count;
      if (do_write && !do_read) begin
         count_next = count + cnt_w'(1);
      end else if (do_read && !do_write) begin
         count_next = count - cnt_w'(1);
      end
   end

   // Storage write.
   always_ff @(posedge clk) begin
      if (do_write) begin
         mem[wr_ptr] <= din;
      end
   end

   // Pointers, count and registered flags.
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         full   <= 1'b0;
         empty  <= 1'b1;  // Nothing stored after reset.
      end else begin
         if (do_write) begin
            wr_ptr <= wr_ptr + ptr_w'(1);  // Wraps at the power-of-two depth.
         end
         if (do_read) begin
            rd_ptr <= rd_ptr + ptr_w'(1);
         end
         count <= count_next;
         full  <= (count_next == cnt_full);  // Rises the cycle after the last fill.
         empty <= (count_next == '0);
      end
   end

   // The serializer must only pop a valid frame.
   a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
      pop |-> !empty)
      else $error("audio_frame_fifo: pop while empty");

endmodule

// File: hw/i2s_bit_clock_gen.sv
`timescale 1ns/1ns

// Bit clock divider.
// bclk toggles every div_count system clocks.
// The strobes fire in the cycle before each bclk edge.
module i2s_bit_clock_gen #(
   parameter int div_count = 25  // Clocks per half bclk period.
) (
   input  logic clk,
   input  logic reset,
   input  logic enable,     // Low stops and clears the divider.
   output logic bclk,
   output logic bclk_fall,  // bclk goes low at the next edge.
   output logic bclk_rise   // bclk goes high at the next edge.
);

   localparam int cnt_w = (div_count > 1) ? $clog2(div_count) : 1;
   localparam logic [cnt_w-1:0] cnt_top = cnt_w'(div_count - 1);

   logic [cnt_w-1:0] div_cnt;  // Position in the half period.
   logic             wrap;     // Last clock of a half period.

   // Half period ends while running.
   assign wrap = enable && (div_cnt == cnt_top);

   // Edge direction from the current level.
   assign bclk_fall = wrap && bclk;
   assign bclk_rise = wrap && !bclk;

   always_ff @(posedge clk) begin
      if (reset || !enable) begin
         div_cnt <= '0;
         bclk    <= 1'b0;  // Idle low.
      end else begin
         if (wrap) begin
            div_cnt <= '0;
            bclk    <= ~bclk;  // Next half period.
         end else begin
            div_cnt <= div_cnt + cnt_w'(1);
         end
      end
   end

   // Only one edge can be pending.
   a_edge_excl: assert property (@(posedge clk) disable iff (reset)
      !(bclk_fall && bclk_rise))
      else $error("i2s_bit_clock_gen: fall and rise strobes together");

endmodule

// File: hw/i2s_serializer.sv
`timescale 1ns/1ns

// I2S slot sequencer and shift register.
// Everything advances on bclk_fall so receivers sample on rising bclk.
// Each slot has 25 bit periods with 24 data bits MSB first and one zero.
module i2s_serializer (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  enable,     // Low clears the serial side.
   input  logic                  bclk_fall,  // bclk goes low next edge.
   input  i2s_pkg::audio_frame_t head,       // Oldest FIFO frame.
   input  logic                  empty,
   output logic                  pop,        // Take head this edge.
   output logic                  lrclk,
   output logic                  sdata,
   output logic                  underrun    // One clk per silent frame.
);

   localparam int sw    = i2s_pkg::sample_width;
   localparam int cnt_w = i2s_pkg::slot_cnt_w;
   localparam logic [cnt_w-1:0] cnt_last = cnt_w'(i2s_pkg::slot_bits - 1);

   i2s_pkg::chan_t        cur_chan;   // Channel now on the wire.
   i2s_pkg::chan_t        next_chan;  // Channel of the next load.
   logic [cnt_w-1:0]      bit_cnt;    // Bit period within the slot.
   logic [sw-1:0]         right_q;    // Right sample of the fetched frame.
   logic [sw-1:0]         shift_q;    // MSB drives sdata.
   logic                  load;       // First edge of a slot.
   logic                  fetch;      // Load of a left slot.

   // Slot start at counter zero.
   assign load  = enable && bclk_fall && (bit_cnt == '0);
   assign fetch = load && (next_chan == i2s_pkg::chan_left);

   // Pop only real frames.
   assign pop = fetch && !empty;

   assign lrclk = (cur_chan == i2s_pkg::chan_right);  // Right channel high.
   assign sdata = shift_q[sw-1];

   // Channel, bit counter and shift register.
   always_ff @(posedge clk) begin
      if (reset || !enable) begin
         cur_chan  <= i2s_pkg::chan_left;
         next_chan <= i2s_pkg::chan_left;  // First slot is left.
         bit_cnt   <= '0;
         shift_q   <= '0;
         underrun  <= 1'b0;
      end else begin
         underrun <= fetch && empty;  // Silent frame substituted.
         if (bclk_fall) begin
            // Bit position wraps after the overhead bit.
            if (bit_cnt == cnt_last) begin
               bit_cnt <= '0;
            end else begin
               bit_cnt <= bit_cnt + cnt_w'(1);
            end

            if (load) begin
               cur_chan <= next_chan;  // lrclk moves with the new MSB.
               if (next_chan == i2s_pkg::chan_left) begin
                  next_chan <= i2s_pkg::chan_right;
                  shift_q   <= empty ? '0 : head.left;  // Straight from the FIFO.
               end else begin
                  next_chan <= i2s_pkg::chan_left;
                  shift_q   <= right_q;  // Latched with the left half.
               end
            end else begin
               shift_q <= {shift_q[sw-2:0], 1'b0};  // Zero fill.
            end
         end
      end
   end

   // Right sample latch.
   // Silence replaces a missing frame.
   always_ff @(posedge clk) begin
      if (fetch) begin
         right_q <= empty ? '0 : head.right;
      end
   end

   // FIFO reads happen only at a slot edge.
   a_pop_on_fall: assert property (@(posedge clk) disable iff (reset)
      pop |-> bclk_fall)
      else $error("i2s_serializer: pop outside bclk_fall");

   // lrclk moves only with a falling bclk while running.
   a_lrclk_on_fall: assert property (@(posedge clk) disable iff (reset)
      ($past(enable) && !$past(reset) && $changed(lrclk)) |-> $past(bclk_fall))
      else $error("i2s_serializer: lrclk changed without bclk_fall");

endmodule

// File: hw/i2s_tx_top.sv
`timescale 1ns/1ns

// I2S transmitter.
// Host frames go through the FIFO and out on bclk, lrclk and sdata.
module i2s_tx_top #(
   parameter int div_count  = 25,  // Half bclk in clk cycles. 2.4 Mbit/s at 120 MHz.
   parameter int fifo_depth = 16   // Frames buffered.
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  enable,       // Serial side run/stop.
   input  i2s_pkg::audio_frame_t frame_in,
   input  logic                  write_frame,  // One-cycle write strobe.
   output logic                  full,
   output logic                  bclk,
   output logic                  lrclk,
   output logic                  sdata,
   output logic                  underrun
);

   i2s_pkg::audio_frame_t head;  // FIFO head frame.
   logic                  empty;
   logic                  pop;
   logic                  bclk_fall;
   logic                  bclk_rise;

   // Host writes land here and the serializer drains them.
   audio_frame_fifo #(
      .fifo_depth(fifo_depth)
   ) audio_frame_fifo_i (
      .clk  (clk),
      .reset(reset),
      .din  (frame_in),
      .wr_en(write_frame),
      .full (full),
      .pop  (pop),
      .head (head),
      .empty(empty)
   );

   i2s_bit_clock_gen #(
      .div_count(div_count)
   ) i2s_bit_clock_gen_i (
      .clk      (clk),
      .reset    (reset),
      .enable   (enable),
      .bclk     (bclk),
      .bclk_fall(bclk_fall),
      .bclk_rise(bclk_rise)
   );

   i2s_serializer i2s_serializer_i (
      .clk      (clk),
      .reset    (reset),
      .enable   (enable),
      .bclk_fall(bclk_fall),
      .head     (head),
      .empty    (empty),
      .pop      (pop),
      .lrclk    (lrclk),
      .sdata    (sdata),
      .underrun (underrun)
   );

   // Data and word select hold across the sampling edge.
   a_stable_at_rise: assert property (@(posedge clk) disable iff (reset || !enable)
      bclk_rise |=> ($stable(sdata) && $stable(lrclk)))
      else $error("i2s_tx_top: serial outputs moved at rising bclk");

endmodule

// File: dv/i2s_tx_tb.sv
`timescale 1ns/1ns

module i2s_tx_tb;

   localparam int div_count   = 3;  // Short bclk for quick runs.
   localparam int fifo_depth  = 4;
   localparam int table_len   = 6;
   localparam int sent_frames = table_len + 1;  // Table plus the recovery frame.
   localparam int total_slots = 2 * (table_len + 3);  // Six frames, two silent, one recovery.
   localparam int data_slots  = 2 * table_len;
   localparam int setup_cycles = 80;  // Reset, idle and FIFO fill.
   localparam int timeout_cycles =
      setup_cycles + (sent_frames + 3) * 2 * i2s_pkg::slot_bits * 2 * div_count;

   logic                  clk = 1'b0;
   logic                  reset;
   logic                  enable;
   i2s_pkg::audio_frame_t frame_in;
   logic                  write_frame;
   logic                  full;
   logic                  bclk;
   logic                  lrclk;
   logic                  sdata;
   logic                  underrun;

   i2s_pkg::audio_frame_t frame_tab [table_len];  // Stimulus table.
   i2s_pkg::audio_frame_t recovery;               // Written after the FIFO ran dry.
   logic [i2s_pkg::slot_bits:0] exp_slots [total_slots];  // {lrclk level, 24 bits, zero}.
   int  n_exp = 0;
   int  seed = 80303;
   int  errs [1:5];  // Failures per test.
   int  cycle_count = 0;

   // Receiver model state.
   logic                        rx_bclk_q = 1'b0;
   logic                        rx_lr = 1'b0;
   logic [i2s_pkg::slot_bits-1:0] rx_word = '0;
   int  rx_edges = 0;
   int  rx_bits = 0;
   int  slots_seen = 0;
   int  rx_shape_errs = 0;
   int  rx_ur_errs = 0;

   // Clock shape monitor state.
   logic shape_prev = 1'b0;
   logic shape_started = 1'b0;
   int   shape_run = 0;
   int   shape_phases = 0;
   int   shape_errs = 0;

   // Underrun monitor state.
   logic ur_prev = 1'b0;
   int   underrun_count = 0;
   int   underrun_errs = 0;

   always #10 clk = ~clk;  // 20 ns period.

   i2s_tx_top #(
      .div_count (div_count),
      .fifo_depth(fifo_depth)
   ) i2s_tx_top_i (
      .clk        (clk),
      .reset      (reset),
      .enable     (enable),
      .frame_in   (frame_in),
      .write_frame(write_frame),
      .full       (full),
      .bclk       (bclk),
      .lrclk      (lrclk),
      .sdata      (sdata),
      .underrun   (underrun)
   );

   // Compare and report. Returns one on a match.
   function automatic bit check_equal(input string name, input logic [31:0] expected,
                                      input logic [31:0] actual);
      bit ok;
      ok = (expected === actual);
      assert (ok) else
         $display("CHECK FAILED at %0t ns: %s expected %0h, got %0h",
                  $time, name, expected, actual);
      return ok;
   endfunction

   // All serial outputs and full low.
   function automatic int idle_errors();
      int n;
      n = 0;
      if (!check_equal("bclk", 0, 32'(bclk))) n++;
      if (!check_equal("lrclk", 0, 32'(lrclk))) n++;
      if (!check_equal("sdata", 0, 32'(sdata))) n++;
      if (!check_equal("underrun", 0, 32'(underrun))) n++;
      if (!check_equal("full", 0, 32'(full))) n++;
      return n;
   endfunction

   function automatic void fill_table();
      logic [31:0] rnd;
      frame_tab[0] = '{left: 24'hffffff, right: 24'hffffff};  // All ones.
      frame_tab[1] = '{left: 24'haaaaaa, right: 24'h555555};  // Alternating bits.
      frame_tab[2] = '{left: 24'h800001, right: 24'h7ffffe};  // End bits.
      frame_tab[3] = '{left: 24'h123456, right: 24'hfedcba};
      for (int i = 4; i < table_len; i++) begin
         rnd = $random(seed);
         frame_tab[i].left = rnd[23:0];
         rnd = $random(seed);
         frame_tab[i].right = rnd[23:0];
      end
      recovery = '{left: frame_tab[3].right, right: frame_tab[3].left};  // Swapped halves.
   endfunction

   // Left slot on lrclk low and right on high, each closed by a zero bit.
   function automatic void record_frame(input i2s_pkg::audio_frame_t f);
      exp_slots[n_exp] = {1'b0, f.left, 1'b0};
      n_exp++;
      exp_slots[n_exp] = {1'b1, f.right, 1'b0};
      n_exp++;
   endfunction

   task automatic send_frame(input i2s_pkg::audio_frame_t f);
      @(posedge clk);
      frame_in    <= f;
      write_frame <= 1'b1;  // One-cycle strobe.
      @(posedge clk);
      write_frame <= 1'b0;
   endtask

   task automatic wait_for_space();
      do begin
         @(posedge clk);
      end while (full);
   endtask

   task automatic report_test(input int num, input string name, input int n);
      $display("Test %0d %s: %s (%0d errors)", num, name, (n == 0) ? "ok" : "FAILED", n);
   endtask

   // Receiver model sampling at rising bclk.
   always @(posedge clk) begin
      if (bclk && !rx_bclk_q) begin
         rx_edges++;
         if (rx_edges > 1) begin  // The first rise comes before the first load.
            if (rx_bits == 0) begin
               // New slot where lrclk toggles. The first slot is left.
               if (!check_equal("lrclk at slot start",
                                (slots_seen == 0) ? 0 : 32'(!rx_lr), 32'(lrclk))) begin
                  rx_shape_errs++;
               end
               rx_lr = lrclk;
            end else if (!check_equal("lrclk within slot", 32'(rx_lr), 32'(lrclk))) begin
               rx_shape_errs++;
            end
            rx_word = {rx_word[i2s_pkg::slot_bits-2:0], sdata};  // MSB first.
            rx_bits++;
            if (rx_bits == i2s_pkg::slot_bits) begin
               if (slots_seen >= n_exp) begin
                  $display("Slot %0d received at %0t ns with no frame written for it",
                           slots_seen, $time);
                  errs[4]++;
               end else if (!check_equal("sdata slot", 32'(exp_slots[slots_seen]),
                                         32'({rx_lr, rx_word}))) begin
                  if (slots_seen < data_slots) errs[4]++;
                  else rx_ur_errs++;  // Silent or recovery slot.
               end
               rx_bits = 0;
               slots_seen++;
            end
         end
      end
      rx_bclk_q = bclk;
   end

   // Every bclk phase lasts div_count clocks while running.
   always @(posedge clk) begin
      if (!enable) begin
         shape_started = 1'b0;  // Partial phases around enable are not timed.
         shape_run = 0;
      end else if (bclk !== shape_prev) begin
         if (shape_started) begin
            shape_phases++;
            if (!check_equal("bclk phase length", div_count, shape_run)) shape_errs++;
         end
         shape_started = 1'b1;
         shape_run = 1;
      end else begin
         shape_run++;
      end
      shape_prev = bclk;
   end

   // Underrun pulses of one clock each.
   always @(posedge clk) begin
      if (underrun) begin
         underrun_count++;
         if (ur_prev) begin
            $display("Underrun held high for more than one clock at %0t ns", $time);
            underrun_errs++;
         end
      end
      ur_prev = underrun;
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= timeout_cycles) begin
         $display("Timeout, the run did not finish within %0d clock cycles", timeout_cycles);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   initial begin
      int ur_snapshot;
      int n3;
      int n4;
      int n5;
      int total;
      int failed;
      reset       <= 1'b1;
      enable      <= 1'b0;
      write_frame <= 1'b0;
      frame_in    <= '0;
      for (int i = 1; i <= 5; i++) errs[i] = 0;
      fill_table();

      // Reset for 10 cycles. Outputs settle after the first edge.
      for (int i = 0; i < 10; i++) begin
         @(posedge clk);
         if (i > 0) errs[1] += idle_errors();
      end
      reset <= 1'b0;
      repeat (10) begin
         @(posedge clk);
         errs[1] += idle_errors();  // Enable still low.
      end
      report_test(1, "reset state", errs[1]);

      // Fill the FIFO with the serial side stopped.
      for (int i = 0; i < fifo_depth; i++) begin
         send_frame(frame_tab[i]);
         record_frame(frame_tab[i]);
         @(posedge clk);
         if (!check_equal("full", 32'(i == fifo_depth - 1), 32'(full))) errs[2]++;
      end
      send_frame(frame_tab[fifo_depth]);  // Dropped since the FIFO is full.
      @(posedge clk);
      if (!check_equal("full", 1, 32'(full))) errs[2]++;
      report_test(2, "FIFO fill", errs[2]);

      enable <= 1'b1;
      for (int i = fifo_depth; i < table_len; i++) begin
         wait_for_space();
         send_frame(frame_tab[i]);
         record_frame(frame_tab[i]);
      end
      // The FIFO runs dry after the table. Two silent frames come before the next write.
      record_frame('0);
      record_frame('0);
      while (underrun_count < 2) @(posedge clk);
      send_frame(recovery);
      record_frame(recovery);
      while (slots_seen < total_slots) @(posedge clk);
      ur_snapshot = underrun_count;
      enable <= 1'b0;
      repeat (5) @(posedge clk);

      errs[3] += idle_errors();  // Stopped and cleared.
      if (shape_phases == 0) begin
         $display("No bclk phase was timed");
         errs[3]++;
      end
      if (!check_equal("underrun pulses", 2, ur_snapshot)) errs[5]++;

      n3 = errs[3] + shape_errs + rx_shape_errs;
      n4 = errs[4];
      n5 = errs[5] + underrun_errs + rx_ur_errs;
      report_test(3, "clock shape", n3);
      report_test(4, "serial data", n4);
      report_test(5, "underrun", n5);

      total  = errs[1] + errs[2] + n3 + n4 + n5;
      failed = 0;
      if (errs[1] != 0) failed++;
      if (errs[2] != 0) failed++;
      if (n3 != 0) failed++;
      if (n4 != 0) failed++;
      if (n5 != 0) failed++;
      $display("Summary: 5 tests, %0d failed, %0d errors, %0d slots checked",
               failed, total, slots_seen);
      if (total == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: i2s_tx_top.f
hw/i2s_pkg.sv
hw/audio_frame_fifo.sv
hw/i2s_bit_clock_gen.sv
hw/i2s_serializer.sv
hw/i2s_tx_top.sv
dv/i2s_tx_tb.sv

// File: Makefile
# Verilator build and run of the I2S transmitter testbench.
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = i2s_tx_tb
FILELIST   = i2s_tx_top.f
OBJ_DIR    = obj_dir
PASS_MSG   = *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulation passes only if the pass message shows up in its output.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
